/* hdl/memSysPkg.sv */
package memSysPkg;

  // One 32-bit data word or byte address
  typedef logic [31:0] wordT;

  // Byte enables, bit n covers byte n of the word
  typedef logic [3:0] byteMaskT;

  // Current holder of the shared memory port
  typedef enum logic [1:0] {
    ownNone  = 2'd0,
    ownInstr = 2'd1,
    ownData  = 2'd2
  } busOwnerE;

  // All four bytes, used for block fills and write-backs
  localparam byteMaskT fullMask = 4'b1111;

  // Replace the enabled bytes of oldWord with those of newWord
  function automatic wordT mergeBytes(wordT oldWord, wordT newWord, byteMaskT mask);
    wordT merged;
    merged = oldWord;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        merged[8*b +: 8] = newWord[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

/* hdl/instrCache.sv */
`timescale 1ns/1ns

module instrCache import memSysPkg::*; #(
  parameter int numLines      = 16,
  parameter int wordsPerBlock = 4
) (
  input  logic clk,
  input  logic rstN,
  input  logic enable,
  input  wordT pcF,
  input  wordT busRData,
  input  logic busReady,
  output wordT instrF,
  output logic iStall,
  output logic busRequest,
  output wordT busAddr
);

  // Address split: tag | index | word offset | byte offset
  localparam int offBits = $clog2(wordsPerBlock);
  localparam int idxBits = $clog2(numLines);
  localparam int tagBits = 30 - offBits - idxBits;

  typedef enum logic [1:0] {sIdle, sFill, sBypass} stateE;

  stateE               state;
  logic [offBits-1:0]  fillCnt;
  logic [numLines-1:0] valid;
  logic [tagBits-1:0]  tagArr [numLines];
  wordT                lineData [numLines][wordsPerBlock];
  wordT                bypassWord;
  logic                bypassValid;
  logic                fetchLive;
  logic [tagBits-1:0]  pcTag;
  logic [idxBits-1:0]  pcIdx;
  logic [offBits-1:0]  pcOff;
  logic                hit;
  logic                lastWord;

  assign pcOff = pcF[offBits+1:2];
  assign pcIdx = pcF[offBits+idxBits+1:offBits+2];
  assign pcTag = pcF[31:offBits+idxBits+2];
  assign hit   = valid[pcIdx] && (tagArr[pcIdx] == pcTag);
  // Block size is a power of two, so all ones marks the final word
  assign lastWord = &fillCnt;

  // Port is requested in every state except idle
  assign busRequest = (state != sIdle);
  // Fill walks the block from word 0; bypass fetches pcF itself
  assign busAddr = (state == sFill) ? {pcTag, pcIdx, fillCnt, 2'b00} : {pcF[31:2], 2'b00};

  always_comb begin
    iStall = 1'b0;
    instrF = lineData[pcIdx][pcOff];
    case (state)
      sIdle: begin
        if (fetchLive) begin
          if (enable) begin
            iStall = !hit;
          end else begin
            // Uncached word comes from the capture register
            iStall = !bypassValid;
            instrF = bypassWord;
          end
        end
      end
      default: iStall = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state       <= sIdle;
      fillCnt     <= '0;
      valid       <= '0;
      bypassValid <= 1'b0;
      fetchLive   <= 1'b0;
    end else begin
      // Core issues its first fetch one cycle after reset release
      fetchLive   <= 1'b1;
      // Captured bypass word is offered for one cycle only
      bypassValid <= (state == sBypass) && busReady;
      case (state)
        sIdle: begin
          if (iStall) begin
            state   <= enable ? sFill : sBypass;
            fillCnt <= '0;
          end
        end
        sFill: begin
          if (busReady) begin
            fillCnt <= fillCnt + 1'b1;
            if (lastWord) begin
              valid[pcIdx] <= 1'b1;
              state        <= sIdle;
            end
          end
        end
        sBypass: begin
          if (busReady) begin
            state <= sIdle;
          end
        end
        default: state <= sIdle;
      endcase
    end
  end

  // Tag and data arrays, plus the bypass capture register
  always_ff @(posedge clk) begin
    if (state == sFill && busReady) begin
      lineData[pcIdx][fillCnt] <= busRData;
      if (lastWord) begin
        tagArr[pcIdx] <= pcTag;
      end
    end
    if (state == sBypass && busReady) begin
      bypassWord <= busRData;
    end
  end

endmodule

/* hdl/dataWritebackCache.sv */
`timescale 1ns/1ns

module dataWritebackCache import memSysPkg::*; #(
  parameter int numLines      = 16,
  parameter int wordsPerBlock = 4
) (
  input  logic     clk,
  input  logic     rstN,
  input  logic     enable,
  input  logic     memWriteM,
  input  logic     memToRegM,
  input  wordT     dataAdrM,
  input  wordT     writeDataM,
  input  byteMaskT byteMaskM,
  input  wordT     busRData,
  input  logic     busReady,
  output wordT     readDataM,
  output logic     dStall,
  output logic     busRequest,
  output logic     busWrite,
  output wordT     busAddr,
  output wordT     busWData,
  output byteMaskT busMask
);

  localparam int offBits = $clog2(wordsPerBlock);
  localparam int idxBits = $clog2(numLines);
  localparam int tagBits = 30 - offBits - idxBits;

  typedef enum logic [1:0] {sIdle, sWriteBack, sFill, sBypass} stateE;

  stateE               state;
  // Word counter shared by write-back and fill
  logic [offBits-1:0]  blkCnt;
  logic [numLines-1:0] valid;
  logic [numLines-1:0] dirty;
  logic [tagBits-1:0]  tagArr [numLines];
  wordT                lineData [numLines][wordsPerBlock];
  wordT                bypassWord;
  logic                bypassValid;
  logic [tagBits-1:0]  adrTag;
  logic [idxBits-1:0]  adrIdx;
  logic [offBits-1:0]  adrOff;
  logic                access;
  logic                hit;
  logic                storeHit;
  logic                lastWord;

  assign adrOff   = dataAdrM[offBits+1:2];
  assign adrIdx   = dataAdrM[offBits+idxBits+1:offBits+2];
  assign adrTag   = dataAdrM[31:offBits+idxBits+2];
  assign access   = memWriteM || memToRegM;
  assign hit      = valid[adrIdx] && (tagArr[adrIdx] == adrTag);
  assign storeHit = (state == sIdle) && enable && memWriteM && hit;
  assign lastWord = &blkCnt;

  assign busRequest = (state != sIdle);
  assign busWrite   = (state == sWriteBack) || ((state == sBypass) && memWriteM);

  // Victim block goes out under its own tag, the fill uses the new one
  always_comb begin
    busAddr  = {dataAdrM[31:2], 2'b00};
    busWData = writeDataM;
    busMask  = byteMaskM;
    case (state)
      sWriteBack: begin
        busAddr  = {tagArr[adrIdx], adrIdx, blkCnt, 2'b00};
        busWData = lineData[adrIdx][blkCnt];
        busMask  = fullMask;
      end
      sFill: begin
        busAddr = {adrTag, adrIdx, blkCnt, 2'b00};
        busMask = fullMask;
      end
      default: ;
    endcase
  end

  always_comb begin
    dStall    = 1'b0;
    readDataM = lineData[adrIdx][adrOff];
    case (state)
      sIdle: begin
        if (access) begin
          if (enable) begin
            dStall = !hit;
          end else begin
            dStall    = !bypassValid;
            readDataM = bypassWord;
          end
        end
      end
      default: dStall = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state       <= sIdle;
      blkCnt      <= '0;
      valid       <= '0;
      dirty       <= '0;
      bypassValid <= 1'b0;
    end else begin
      bypassValid <= (state == sBypass) && busReady;
      case (state)
        sIdle: begin
          if (storeHit) begin
            dirty[adrIdx] <= 1'b1;
          end
          if (dStall) begin
            blkCnt <= '0;
            if (!enable) begin
              state <= sBypass;
            end else if (valid[adrIdx] && dirty[adrIdx]) begin
              state <= sWriteBack;
            end else begin
              state <= sFill;
            end
          end
        end
        sWriteBack: begin
          if (busReady) begin
            // Counter wraps to zero, ready for the fill
            blkCnt <= blkCnt + 1'b1;
            if (lastWord) begin
              state <= sFill;
            end
          end
        end
        sFill: begin
          if (busReady) begin
            blkCnt <= blkCnt + 1'b1;
            if (lastWord) begin
              valid[adrIdx] <= 1'b1;
              dirty[adrIdx] <= 1'b0;
              state         <= sIdle;
            end
          end
        end
        sBypass: begin
          if (busReady) begin
            state <= sIdle;
          end
        end
        default: state <= sIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == sFill && busReady) begin
      lineData[adrIdx][blkCnt] <= busRData;
      if (lastWord) begin
        tagArr[adrIdx] <= adrTag;
      end
    end else if (storeHit || (state == sBypass && busReady && memWriteM && hit)) begin
      // Uncached store to a resident line also updates the line, keeping it coherent
      lineData[adrIdx][adrOff] <= mergeBytes(lineData[adrIdx][adrOff], writeDataM, byteMaskM);
    end
    if (state == sBypass && busReady && !memWriteM) begin
      // Resident line may hold newer data than memory
      bypassWord <= hit ? lineData[adrIdx][adrOff] : busRData;
    end
  end

endmodule

/* hdl/busArbiter.sv */
`timescale 1ns/1ns

module busArbiter import memSysPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  logic     iRequest,
  input  wordT     iAddr,
  input  logic     dRequest,
  input  logic     dWrite,
  input  wordT     dAddr,
  input  wordT     dWData,
  input  byteMaskT dMask,
  input  logic     busReady,
  output logic     busRequest,
  output logic     busWrite,
  output wordT     busAddr,
  output wordT     busWData,
  output byteMaskT busMask,
  output logic     iReady,
  output logic     dReady,
  output busOwnerE owner
);

  busOwnerE ownerQ;

  // Holder keeps the port while its request stays up, else data side first
  always_comb begin
    if (ownerQ == ownData && dRequest) begin
      owner = ownData;
    end else if (ownerQ == ownInstr && iRequest) begin
      owner = ownInstr;
    end else if (dRequest) begin
      owner = ownData;
    end else if (iRequest) begin
      owner = ownInstr;
    end else begin
      owner = ownNone;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ownerQ <= ownNone;
    end else begin
      ownerQ <= owner;
    end
  end

  assign busRequest = (owner != ownNone);
  // Instruction side only reads
  assign busWrite = (owner == ownData) && dWrite;
  assign busAddr  = (owner == ownData) ? dAddr : iAddr;
  assign busWData = (owner == ownData) ? dWData : '0;
  assign busMask  = (owner == ownData) ? dMask : fullMask;
  // Ready goes back to the current holder only
  assign iReady = busReady && (owner == ownInstr);
  assign dReady = busReady && (owner == ownData);

endmodule

/* hdl/ahbMemory.sv */
`timescale 1ns/1ns

module ahbMemory import memSysPkg::*; #(
  parameter int waitStates = 2,
  parameter int memWords   = 1024
) (
  input  logic     clk,
  input  logic     rstN,
  input  logic     busRequest,
  input  logic     busWrite,
  input  wordT     busAddr,
  input  wordT     busWData,
  input  byteMaskT busMask,
  output wordT     busRData,
  output logic     busReady
);

  localparam int addrBits = $clog2(memWords);
  // Counter must reach waitStates, at least one bit wide
  localparam int cntBits  = (waitStates > 0) ? $clog2(waitStates + 1) : 1;

  wordT                mem [memWords];
  logic [cntBits-1:0]  waitCnt;
  logic [addrBits-1:0] wordIdx;

  // Word address, upper bits ignored so the space wraps
  assign wordIdx = busAddr[addrBits+1:2];

  // Ready once waitStates cycles of request have passed
  assign busReady = busRequest && (waitCnt == cntBits'(waitStates));
  assign busRData = mem[wordIdx];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      waitCnt <= '0;
    end else if (busReady || !busRequest) begin
      // Next transfer counts from its own first request cycle
      waitCnt <= '0;
    end else begin
      waitCnt <= waitCnt + 1'b1;
    end
  end

  // Masked write lands on the ready edge
  always @(posedge clk) begin
    if (busReady && busWrite) begin
      mem[wordIdx] <= mergeBytes(mem[wordIdx], busWData, busMask);
    end
  end

  // Each word starts out holding its own byte address
  initial begin
    for (int w = 0; w < memWords; w++) begin
      mem[w] = wordT'(w * 4);
    end
  end

endmodule

/* hdl/memSystemTop.sv */
`timescale 1ns/1ns

module memSystemTop import memSysPkg::*; #(
  parameter int numLines      = 16,
  parameter int wordsPerBlock = 4,
  parameter int waitStates    = 2,
  parameter int memWords      = 1024
) (
  input  logic     clk,
  input  logic     rstN,
  input  logic     iEnable,
  input  logic     dEnable,
  input  wordT     pcF,
  input  logic     memWriteM,
  input  logic     memToRegM,
  input  wordT     dataAdrM,
  input  wordT     writeDataM,
  input  byteMaskT byteMaskM,
  output wordT     instrF,
  output logic     iStall,
  output wordT     readDataM,
  output logic     dStall
);

  // Instruction cache side of the arbiter
  logic     iBusRequest;
  logic     iBusReady;
  wordT     iBusAddr;

  // Data cache side of the arbiter
  logic     dBusRequest;
  logic     dBusWrite;
  logic     dBusReady;
  wordT     dBusAddr;
  wordT     dBusWData;
  byteMaskT dBusMask;

  // Shared port between arbiter and memory
  logic     busRequest;
  logic     busWrite;
  logic     busReady;
  wordT     busAddr;
  wordT     busWData;
  wordT     busRData;
  byteMaskT busMask;
  busOwnerE busOwner;

  instrCache #(
    .numLines(numLines),
    .wordsPerBlock(wordsPerBlock)
  ) instrCacheInst (
    .clk(clk), .rstN(rstN), .enable(iEnable), .pcF(pcF),
    .busRData(busRData), .busReady(iBusReady),
    .instrF(instrF), .iStall(iStall),
    .busRequest(iBusRequest), .busAddr(iBusAddr)
  );

  dataWritebackCache #(
    .numLines(numLines),
    .wordsPerBlock(wordsPerBlock)
  ) dataCacheInst (
    .clk(clk), .rstN(rstN), .enable(dEnable),
    .memWriteM(memWriteM), .memToRegM(memToRegM), .dataAdrM(dataAdrM),
    .writeDataM(writeDataM), .byteMaskM(byteMaskM),
    .busRData(busRData), .busReady(dBusReady),
    .readDataM(readDataM), .dStall(dStall),
    .busRequest(dBusRequest), .busWrite(dBusWrite), .busAddr(dBusAddr),
    .busWData(dBusWData), .busMask(dBusMask)
  );

  busArbiter arbiterInst (
    .clk(clk), .rstN(rstN),
    .iRequest(iBusRequest), .iAddr(iBusAddr),
    .dRequest(dBusRequest), .dWrite(dBusWrite), .dAddr(dBusAddr),
    .dWData(dBusWData), .dMask(dBusMask), .busReady(busReady),
    .busRequest(busRequest), .busWrite(busWrite), .busAddr(busAddr),
    .busWData(busWData), .busMask(busMask),
    .iReady(iBusReady), .dReady(dBusReady), .owner(busOwner)
  );

  // Wait-state memory on the shared port
  ahbMemory #(
    .waitStates(waitStates),
    .memWords(memWords)
  ) memoryInst (
    .clk(clk), .rstN(rstN),
    .busRequest(busRequest), .busWrite(busWrite), .busAddr(busAddr),
    .busWData(busWData), .busMask(busMask),
    .busRData(busRData), .busReady(busReady)
  );

endmodule

/* tb/memSystemChecker.sv */
`timescale 1ns/1ns

module memSystemChecker import memSysPkg::*; #(
  parameter int stallLimit = 64,
  parameter int waitStates = 2
) (
  input logic     clk,
  input logic     rstN,
  input logic     busRequest,
  input logic     busReady,
  input busOwnerE busOwner,
  input logic     iBusRequest,
  input logic     dBusRequest,
  input logic     iStall,
  input logic     dStall
);

  // Start of the wait period as seen from the ready cycle
  localparam int lookBack = (waitStates > 0) ? waitStates : 1;

  // Count of failed assertions read back by the testbench
  int assertFails = 0;

  // Memory only answers a request that has waited out its wait states
  readyNeedsRequest: assert property (
    @(posedge clk) disable iff (!rstN)
      busReady |-> busRequest && (waitStates == 0 || $past(busRequest, lookBack))
  ) else begin
    $error("busReady seen without a request held through the wait states");
    assertFails++;
  end

  // Data side keeps the port while its request stays up
  dataOwnerHeld: assert property (
    @(posedge clk) disable iff (!rstN)
      (busOwner == ownData) ##1 dBusRequest |-> (busOwner == ownData)
  ) else begin
    $error("Port taken from data side during its request");
    assertFails++;
  end

  // Same for the instruction side
  instrOwnerHeld: assert property (
    @(posedge clk) disable iff (!rstN)
      (busOwner == ownInstr) ##1 iBusRequest |-> (busOwner == ownInstr)
  ) else begin
    $error("Port taken from instruction side during its request");
    assertFails++;
  end

  // No access is pending in the first cycle out of reset
  stallsLowAfterReset: assert property (
    @(posedge clk) $rose(rstN) |-> (!iStall && !dStall)
  ) else begin
    $error("Stall output high in first cycle after reset");
    assertFails++;
  end

  iStallBounded: assert property (
    @(posedge clk) disable iff (!rstN) $rose(iStall) |-> ##[1:stallLimit] !iStall
  ) else begin
    $error("iStall stayed high too long");
    assertFails++;
  end

  dStallBounded: assert property (
    @(posedge clk) disable iff (!rstN) $rose(dStall) |-> ##[1:stallLimit] !dStall
  ) else begin
    $error("dStall stayed high too long");
    assertFails++;
  end

endmodule

/* tb/memSystemTb.sv */
`timescale 1ns/1ns

module memSystemTb
  import memSysPkg::*;
();

  localparam int refWords   = 1024;
  // Cycles one row may stall before it counts as hung
  localparam int rowTimeout = 200;

  typedef enum logic [1:0] {opFetch, opLoad, opStore, opBoth} opE;

  // One stimulus row where pc serves fetches and adr serves data accesses
  typedef struct {
    opE       op;
    logic     iEn;
    logic     dEn;
    wordT     pc;
    wordT     adr;
    wordT     wData;
    byteMaskT mask;
    logic     expectHit;
  } rowT;

  logic     clk;
  logic     rstN;
  logic     iEnable;
  logic     dEnable;
  wordT     pcF;
  logic     memWriteM;
  logic     memToRegM;
  wordT     dataAdrM;
  wordT     writeDataM;
  byteMaskT byteMaskM;
  wordT     instrF;
  logic     iStall;
  wordT     readDataM;
  logic     dStall;

  // Memory contents as the core should see them
  wordT refMem [refWords];
  rowT  rowTable [$];
  int   checks;
  int   errors;
  int   rowsFailed;
  bit   timedOut;

  memSystemTop #(
    .memWords(refWords)
  ) i_dut (
    .clk(clk), .rstN(rstN), .iEnable(iEnable), .dEnable(dEnable), .pcF(pcF),
    .memWriteM(memWriteM), .memToRegM(memToRegM), .dataAdrM(dataAdrM),
    .writeDataM(writeDataM), .byteMaskM(byteMaskM),
    .instrF(instrF), .iStall(iStall), .readDataM(readDataM), .dStall(dStall)
  );

  bind memSystemTop memSystemChecker #(
    .waitStates(waitStates)
  ) checkerInst (
    .clk(clk), .rstN(rstN), .busRequest(busRequest), .busReady(busReady),
    .busOwner(busOwner), .iBusRequest(iBusRequest), .dBusRequest(dBusRequest),
    .iStall(iStall), .dStall(dStall)
  );

  always #50 clk = ~clk;

  // Byte lanes selected by the mask come from the new word
  function automatic wordT maskedWrite(wordT oldWord, wordT newWord, byteMaskT mask);
    wordT lanes;
    lanes = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    return (oldWord & ~lanes) | (newWord & lanes);
  endfunction

  task automatic compareValue(input wordT actual, input wordT expected, input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR @%0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  function automatic void addRow(opE op, logic iEn, logic dEn, wordT pc, wordT adr,
                                 wordT wData, byteMaskT mask, logic expectHit);
    rowT r;
    r.op        = op;
    r.iEn       = iEn;
    r.dEn       = dEn;
    r.pc        = pc;
    r.adr       = adr;
    r.wData     = wData;
    r.mask      = mask;
    r.expectHit = expectHit;
    rowTable.push_back(r);
  endfunction

  function automatic void buildTable();
    // Cold misses, then hits in the same blocks
    addRow(opFetch, 1, 1, 32'h040, 32'h000, 32'h0, 4'h0, 0);
    addRow(opFetch, 1, 1, 32'h044, 32'h000, 32'h0, 4'h0, 1);
    addRow(opLoad,  1, 1, 32'h000, 32'h200, 32'h0, 4'h0, 0);
    addRow(opLoad,  1, 1, 32'h000, 32'h20c, 32'h0, 4'h0, 1);
    addRow(opFetch, 1, 1, 32'h048, 32'h000, 32'h0, 4'h0, 1);
    // Byte-masked store hits merging into one word
    addRow(opStore, 1, 1, 32'h000, 32'h208, 32'haabbccdd, 4'b0001, 1);
    addRow(opStore, 1, 1, 32'h000, 32'h208, 32'h11223344, 4'b0110, 1);
    addRow(opStore, 1, 1, 32'h000, 32'h208, 32'h55667788, 4'b1000, 1);
    addRow(opLoad,  1, 1, 32'h000, 32'h208, 32'h0, 4'h0, 1);
    // Same index under a new tag sends the dirty block back to memory
    addRow(opLoad,  1, 1, 32'h000, 32'h300, 32'h0, 4'h0, 0);
    addRow(opLoad,  1, 1, 32'h000, 32'h208, 32'h0, 4'h0, 0);
    addRow(opStore, 1, 1, 32'h000, 32'h314, 32'h0badbeef, 4'b1100, 0);
    addRow(opLoad,  1, 1, 32'h000, 32'h414, 32'h0, 4'h0, 0);
    addRow(opLoad,  1, 1, 32'h000, 32'h314, 32'h0, 4'h0, 0);
    // Both caches off so every access is a single uncached word
    addRow(opLoad,  0, 0, 32'h000, 32'h208, 32'h0, 4'h0, 0);
    addRow(opStore, 0, 0, 32'h000, 32'h500, 32'h12345678, 4'b0011, 0);
    addRow(opLoad,  0, 0, 32'h000, 32'h500, 32'h0, 4'h0, 0);
    addRow(opFetch, 0, 0, 32'h050, 32'h000, 32'h0, 4'h0, 0);
    addRow(opStore, 0, 0, 32'h000, 32'h208, 32'hdeadbeef, 4'b0100, 0);
    addRow(opLoad,  0, 0, 32'h000, 32'h208, 32'h0, 4'h0, 0);
    addRow(opBoth,  0, 0, 32'h0a0, 32'h314, 32'h0, 4'h0, 0);
    // Caches back on with fetch and load missing together
    addRow(opBoth,  1, 1, 32'h0c0, 32'h600, 32'h0, 4'h0, 0);
    addRow(opBoth,  1, 1, 32'h0c4, 32'h608, 32'h0, 4'h0, 1);
    addRow(opStore, 1, 1, 32'h000, 32'h520, 32'ha5a5a5a5, 4'b1111, 0);
    addRow(opLoad,  1, 1, 32'h000, 32'h500, 32'h0, 4'h0, 0);
    addRow(opBoth,  1, 1, 32'h0c8, 32'h208, 32'h0, 4'h0, 0);
    addRow(opLoad,  1, 1, 32'h000, 32'h520, 32'h0, 4'h0, 1);
    addRow(opLoad,  1, 1, 32'h000, 32'h720, 32'h0, 4'h0, 0);
    addRow(opLoad,  1, 1, 32'h000, 32'h520, 32'h0, 4'h0, 0);
  endfunction

  // Entered and left 1 ns after a rising edge
  task automatic runRow(input int idx, input rowT r);
    bit   fetchOn;
    bit   dataOn;
    bit   fetchDone;
    bit   dataDone;
    bit   sawI;
    bit   sawD;
    int   cycles;
    int   waitCycles;
    int   errBefore;
    wordT expInstr;
    wordT expData;
    errBefore  = errors;
    fetchOn    = (r.op == opFetch) || (r.op == opBoth);
    dataOn     = (r.op != opFetch);
    fetchDone  = !fetchOn;
    dataDone   = !dataOn;
    sawI       = 0;
    sawD       = 0;
    cycles     = 0;
    waitCycles = 0;
    // A new pc is only presented once the running fetch has finished
    while (fetchOn && r.pc !== pcF && iStall && waitCycles < rowTimeout) begin
      @(posedge clk);
      #1;
      waitCycles++;
    end
    if (fetchOn && r.pc !== pcF && iStall) begin
      $display("Row %0d timed out, the previous fetch never finished", idx);
      timedOut = 1;
    end
    expInstr = refMem[r.pc[11:2]];
    expData  = refMem[r.adr[11:2]];
    iEnable  = r.iEn;
    dEnable  = r.dEn;
    if (fetchOn) begin
      pcF = r.pc;
    end
    if (dataOn) begin
      dataAdrM   = r.adr;
      writeDataM = r.wData;
      byteMaskM  = r.mask;
      memWriteM  = (r.op == opStore);
      memToRegM  = (r.op != opStore);
    end
    while (!timedOut && !(fetchDone && dataDone) && cycles < rowTimeout) begin
      @(negedge clk);
      if (cycles == 0 && r.expectHit) begin
        if (fetchOn) begin
          compareValue(iStall, 0, $sformatf("row %0d iStall on hit", idx));
        end
        if (dataOn) begin
          compareValue(dStall, 0, $sformatf("row %0d dStall on hit", idx));
        end
      end
      // An uncached word only counts once its own stall was seen
      if (!fetchDone) begin
        if (iStall) begin
          sawI = 1;
        end else if (r.iEn || sawI) begin
          fetchDone = 1;
          compareValue(instrF, expInstr, $sformatf("row %0d instrF at %h", idx, r.pc));
        end
      end
      if (!dataDone) begin
        if (dStall) begin
          sawD = 1;
        end else if (r.dEn || sawD) begin
          dataDone = 1;
          if (r.op == opStore) begin
            refMem[r.adr[11:2]] = maskedWrite(refMem[r.adr[11:2]], r.wData, r.mask);
          end else begin
            compareValue(readDataM, expData, $sformatf("row %0d load at %h", idx, r.adr));
          end
        end
      end
      cycles++;
      @(posedge clk);
      #1;
      // Finished data access is withdrawn while a fetch may still run
      if (dataDone) begin
        memWriteM = 0;
        memToRegM = 0;
      end
    end
    if (!timedOut && !(fetchDone && dataDone)) begin
      $display("Row %0d timed out, a stall output stayed high for %0d cycles", idx, cycles);
      timedOut = 1;
    end
    if (timedOut || errors != errBefore) begin
      rowsFailed++;
    end
    $display("row %0d %s: %s", idx, r.op.name(), (timedOut || errors != errBefore) ?
             "FAILED" : "ok");
  endtask

  initial begin
    int rowsRun;
    int assertFails;
    clk        = 0;
    rstN       = 0;
    iEnable    = 1;
    dEnable    = 1;
    pcF        = 32'h040;
    memWriteM  = 0;
    memToRegM  = 0;
    dataAdrM   = '0;
    writeDataM = '0;
    byteMaskM  = '0;
    checks     = 0;
    errors     = 0;
    rowsFailed = 0;
    rowsRun    = 0;
    timedOut   = 0;
    // Every word starts out holding its own byte address
    for (int w = 0; w < refWords; w++) begin
      refMem[w] = wordT'(w) << 2;
    end
    buildTable();
    repeat (5) @(posedge clk);
    #1;
    rstN = 1;
    @(posedge clk);
    #1;
    for (int i = 0; i < rowTable.size() && !timedOut; i++) begin
      runRow(i, rowTable[i]);
      rowsRun++;
    end
    assertFails = i_dut.checkerInst.assertFails;
    $display("Rows %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             rowsRun, rowsFailed, checks, errors, assertFails);
    if (errors == 0 && rowsFailed == 0 && !timedOut && assertFails == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* project.f */
hdl/memSysPkg.sv
hdl/instrCache.sv
hdl/dataWritebackCache.sv
hdl/busArbiter.sv
hdl/ahbMemory.sv
hdl/memSystemTop.sv
tb/memSystemChecker.sv
tb/memSystemTb.sv
